/* verilog/rvseed_pkg.sv */
package rvseed_pkg;

    typedef logic [63:0] xlen_t;     // architectural data word
    typedef logic [63:0] addr_t;     // byte address
    typedef logic [31:0] inst_t;
    typedef logic [4:0]  reg_idx_t;

    // ********************************************************************
    // major opcodes
    // ********************************************************************
    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_op_32  = 7'b0111011;
    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_load   = 7'b0000011;
    localparam logic [6:0] opc_store  = 7'b0100011;
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_jal    = 7'b1101111;

    typedef enum logic [3:0] {
        alu_add    = 4'd0,
        alu_sub    = 4'd1,
        alu_and    = 4'd2,
        alu_or     = 4'd3,
        alu_xor    = 4'd4,
        alu_slt    = 4'd5,
        alu_sltu   = 4'd6,
        alu_sll    = 4'd7,
        alu_srl    = 4'd8,
        alu_sra    = 4'd9,
        alu_addw   = 4'd10,
        alu_sllw   = 4'd11,
        alu_pass_b = 4'd12,
        alu_seq    = 4'd13,
        alu_sne    = 4'd14
    } alu_op_e;

    typedef enum logic [1:0] {
        size_bu = 2'd0,   // byte, zero extended
        size_w  = 2'd1,   // word, sign extended
        size_d  = 2'd2
    } mem_size_e;

    typedef enum logic [2:0] {
        br_none = 3'd0,
        br_eq   = 3'd1,
        br_ne   = 3'd2,
        br_lt   = 3'd3,
        br_ltu  = 3'd4,
        br_jal  = 3'd5
    } branch_e;

    typedef struct packed {
        alu_op_e   alu_op;
        logic      src2_imm;   // second alu operand is the immediate
        logic      reg_we;
        logic      mem_rd;
        logic      mem_wr;
        mem_size_e mem_size;
        branch_e   branch;
        logic      wb_pc4;     // write pc+4 back to rd
    } ctrl_t;

    typedef struct packed {
        addr_t       addr;     // doubleword aligned
        xlen_t       wdata;
        logic [7:0]  be;
        logic        we;
    } dmem_req_t;

endpackage

/* verilog/rvseed_ctrl.sv */
`timescale 1ns/1ps

module rvseed_ctrl import rvseed_pkg::*; (
    input  inst_t instr,
    output ctrl_t ctrl
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    always_comb begin
        ctrl = '0;   // nop unless decoded below
        case (opcode)
            opc_op: begin
                ctrl.reg_we = 1'b1;
                case ({funct7, funct3})
                    {7'h00, 3'b000}: ctrl.alu_op = alu_add;
                    {7'h20, 3'b000}: ctrl.alu_op = alu_sub;
                    {7'h00, 3'b001}: ctrl.alu_op = alu_sll;
                    {7'h00, 3'b010}: ctrl.alu_op = alu_slt;
                    {7'h00, 3'b011}: ctrl.alu_op = alu_sltu;
                    {7'h00, 3'b100}: ctrl.alu_op = alu_xor;
                    {7'h00, 3'b101}: ctrl.alu_op = alu_srl;
                    {7'h20, 3'b101}: ctrl.alu_op = alu_sra;
                    {7'h00, 3'b110}: ctrl.alu_op = alu_or;
                    {7'h00, 3'b111}: ctrl.alu_op = alu_and;
                    default:         ctrl.reg_we = 1'b0;
                endcase
            end
            opc_op_32: begin
                ctrl.reg_we = 1'b1;
                case ({funct7, funct3})
                    {7'h00, 3'b000}: ctrl.alu_op = alu_addw;
                    {7'h00, 3'b001}: ctrl.alu_op = alu_sllw;
                    default:         ctrl.reg_we = 1'b0;
                endcase
            end
            opc_op_imm: begin
                if (funct3 == 3'b000) begin   // addi only
                    ctrl.alu_op   = alu_add;
                    ctrl.src2_imm = 1'b1;
                    ctrl.reg_we   = 1'b1;
                end
            end
            opc_lui: begin
                ctrl.alu_op   = alu_pass_b;
                ctrl.src2_imm = 1'b1;
                ctrl.reg_we   = 1'b1;
            end
            opc_load: begin
                ctrl.alu_op   = alu_add;
                ctrl.src2_imm = 1'b1;
                case (funct3)
                    3'b011: ctrl.mem_size = size_d;
                    3'b010: ctrl.mem_size = size_w;
                    3'b100: ctrl.mem_size = size_bu;
                    default: ctrl.mem_size = size_bu;
                endcase
                ctrl.mem_rd = (funct3 == 3'b011) || (funct3 == 3'b010) || (funct3 == 3'b100);
                ctrl.reg_we = ctrl.mem_rd;
            end
            opc_store: begin
                ctrl.alu_op   = alu_add;
                ctrl.src2_imm = 1'b1;
                case (funct3)
                    3'b011: ctrl.mem_size = size_d;
                    3'b010: ctrl.mem_size = size_w;
                    default: ctrl.mem_size = size_bu;
                endcase
                ctrl.mem_wr = (funct3 == 3'b011) || (funct3 == 3'b010) || (funct3 == 3'b000);
            end
            opc_branch: begin
                case (funct3)
                    3'b000: begin
                        ctrl.alu_op = alu_seq;
                        ctrl.branch = br_eq;
                    end
                    3'b001: begin
                        ctrl.alu_op = alu_sne;
                        ctrl.branch = br_ne;
                    end
                    3'b100: begin
                        ctrl.alu_op = alu_slt;
                        ctrl.branch = br_lt;
                    end
                    3'b110: begin
                        ctrl.alu_op = alu_sltu;
                        ctrl.branch = br_ltu;
                    end
                    default: ctrl.branch = br_none;
                endcase
            end
            opc_jal: begin
                ctrl.branch = br_jal;
                ctrl.reg_we = 1'b1;
                ctrl.wb_pc4 = 1'b1;
            end
            default: ctrl = '0;
        endcase
    end

    // a load and a store never share one instruction slot
    assert final (!(ctrl.mem_rd && ctrl.mem_wr))
        else $error("ctrl: mem_rd and mem_wr both set for instr %h", instr);

endmodule

/* verilog/alu.sv */
`timescale 1ns/1ps

module alu import rvseed_pkg::*; (
    input  alu_op_e op,
    input  xlen_t   src1,
    input  xlen_t   src2,
    output xlen_t   result,
    output logic    cond
);

    logic [31:0] sum_w;
    logic [31:0] sll_w;
    logic        lt_s;
    logic        lt_u;

    assign sum_w = src1[31:0] + src2[31:0];
    assign sll_w = src1[31:0] << src2[4:0];   // word shifts use 5 bits
    assign lt_s  = $signed(src1) < $signed(src2);
    assign lt_u  = src1 < src2;

    // ********************************************************************
    // result
    // ********************************************************************
    always_comb begin
        result = '0;
        case (op)
            alu_add:    result = src1 + src2;
            alu_sub:    result = src1 - src2;
            alu_and:    result = src1 & src2;
            alu_or:     result = src1 | src2;
            alu_xor:    result = src1 ^ src2;
            alu_slt:    result = {63'b0, lt_s};
            alu_sltu:   result = {63'b0, lt_u};
            alu_sll:    result = src1 << src2[5:0];
            alu_srl:    result = src1 >> src2[5:0];
            alu_sra:    result = xlen_t'($signed(src1) >>> src2[5:0]);
            alu_addw:   result = {{32{sum_w[31]}}, sum_w};
            alu_sllw:   result = {{32{sll_w[31]}}, sll_w};
            alu_pass_b: result = src2;   // lui
            default:    result = '0;
        endcase
    end

    // ********************************************************************
    // branch condition
    // ********************************************************************
    always_comb begin
        case (op)
            alu_seq:  cond = (src1 == src2);
            alu_sne:  cond = (src1 != src2);
            alu_slt:  cond = lt_s;
            alu_sltu: cond = lt_u;
            default:  cond = 1'b0;
        endcase
    end

endmodule

/* verilog/reg_file.sv */
`timescale 1ns/1ps

module reg_file import rvseed_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  reg_idx_t rs1_addr,
    input  reg_idx_t rs2_addr,
    input  reg_idx_t rd_addr,
    input  logic     we,
    input  xlen_t    rd_data,
    output xlen_t    rs1_data,
    output xlen_t    rs2_data
);

    xlen_t regs [1:31];   // x0 is not stored

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (rd_addr != '0)) begin
            regs[rd_addr] <= rd_data;
        end
    end

    // reads see the old value when rd collides
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

/* verilog/imm_gen.sv */
`timescale 1ns/1ps

module imm_gen import rvseed_pkg::*; (
    input  inst_t instr,
    output xlen_t imm
);

    xlen_t imm_i;
    xlen_t imm_s;
    xlen_t imm_b;
    xlen_t imm_u;
    xlen_t imm_j;

    assign imm_i = {{52{instr[31]}}, instr[31:20]};
    assign imm_s = {{52{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{51{instr[31]}}, instr[31], instr[7], instr[30:25],
                    instr[11:8], 1'b0};
    assign imm_u = {{32{instr[31]}}, instr[31:12], 12'b0};
    assign imm_j = {{43{instr[31]}}, instr[31], instr[19:12], instr[20],
                    instr[30:21], 1'b0};

    // format follows the major opcode alone
    always_comb begin
        case (instr[6:0])
            opc_op_imm,
            opc_load:   imm = imm_i;
            opc_store:  imm = imm_s;
            opc_branch: imm = imm_b;
            opc_lui:    imm = imm_u;
            opc_jal:    imm = imm_j;
            default:    imm = '0;   // r-type has no immediate
        endcase
    end

endmodule

/* verilog/lsu.sv */
`timescale 1ns/1ps

module lsu import rvseed_pkg::*; (
    input  ctrl_t     ctrl,
    input  addr_t     addr,
    input  xlen_t     store_data,
    input  xlen_t     dmem_rdata,
    output dmem_req_t dmem_req,
    output xlen_t     load_data
);

    logic [2:0] lane;
    xlen_t      rdata_sh;

    assign lane     = addr[2:0];
    assign rdata_sh = dmem_rdata >> {lane, 3'b000};   // selected lane to bit 0

    // ********************************************************************
    // store side
    // ********************************************************************
    always_comb begin
        dmem_req.addr  = {addr[63:3], 3'b000};
        dmem_req.we    = ctrl.mem_wr;
        dmem_req.be    = '0;
        dmem_req.wdata = store_data;
        case (ctrl.mem_size)
            size_bu: begin
                dmem_req.be    = 8'b0000_0001 << lane;
                dmem_req.wdata = {8{store_data[7:0]}};
            end
            size_w: begin
                dmem_req.be    = 8'b0000_1111 << lane;   // lane is 0 or 4
                dmem_req.wdata = {2{store_data[31:0]}};
            end
            default: begin
                dmem_req.be    = 8'hff;
                dmem_req.wdata = store_data;
            end
        endcase
        if (!ctrl.mem_wr) begin
            dmem_req.be = '0;
        end
    end

    // ********************************************************************
    // load side
    // ********************************************************************
    always_comb begin
        case (ctrl.mem_size)
            size_bu: load_data = {56'b0, rdata_sh[7:0]};
            size_w:  load_data = {{32{rdata_sh[31]}}, rdata_sh[31:0]};
            default: load_data = dmem_rdata;
        endcase
    end

    // word and double accesses must be naturally aligned
    assert final (!(ctrl.mem_rd || ctrl.mem_wr)
                  || (ctrl.mem_size == size_bu)
                  || ((ctrl.mem_size == size_w) && (addr[1:0] == 2'b00))
                  || ((ctrl.mem_size == size_d) && (addr[2:0] == 3'b000)))
        else $error("lsu: misaligned access at %h", addr);

endmodule

/* verilog/pc_unit.sv */
`timescale 1ns/1ps

module pc_unit import rvseed_pkg::*; #(
    parameter addr_t reset_pc = '0
) (
    input  logic    clk,
    input  logic    rst,
    input  branch_e branch,
    input  logic    cond,
    input  xlen_t   imm,
    output addr_t   pc
);

    logic  taken;
    addr_t pc_next;

    // conditional branches rely on the alu flag
    always_comb begin
        case (branch)
            br_jal:  taken = 1'b1;
            br_none: taken = 1'b0;
            default: taken = cond;
        endcase
    end

    assign pc_next = taken ? (pc + imm) : (pc + addr_t'(4));

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= reset_pc;
        end else begin
            pc <= pc_next;
        end
    end

    // fetch stays on instruction boundaries, including after reset
    pc_aligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00)
        else $error("pc_unit: pc %h not word aligned", pc);

endmodule

/* verilog/rvseed_core.sv */
`timescale 1ns/1ps

module rvseed_core import rvseed_pkg::*; #(
    parameter addr_t reset_pc = '0
) (
    input  logic      clk,
    input  logic      rst,
    output addr_t     pc,
    input  inst_t     instr,
    output dmem_req_t dmem_req,
    input  xlen_t     dmem_rdata
);

    ctrl_t     ctrl;
    xlen_t     imm;
    xlen_t     rs1_data;
    xlen_t     rs2_data;
    xlen_t     alu_src2;
    xlen_t     alu_result;
    logic      alu_cond;
    xlen_t     load_data;
    xlen_t     wb_data;
    dmem_req_t lsu_req;

    rvseed_ctrl u_ctrl (.instr(instr), .ctrl(ctrl));

    imm_gen u_imm (.instr(instr), .imm(imm));

    reg_file u_rf (
        .clk      (clk),
        .rst      (rst),
        .rs1_addr (instr[19:15]),
        .rs2_addr (instr[24:20]),
        .rd_addr  (instr[11:7]),
        .we       (ctrl.reg_we),
        .rd_data  (wb_data),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    assign alu_src2 = ctrl.src2_imm ? imm : rs2_data;

    alu u_alu (
        .op     (ctrl.alu_op),
        .src1   (rs1_data),
        .src2   (alu_src2),
        .result (alu_result),
        .cond   (alu_cond)
    );

    lsu u_lsu (
        .ctrl       (ctrl),
        .addr       (alu_result),
        .store_data (rs2_data),
        .dmem_rdata (dmem_rdata),
        .dmem_req   (lsu_req),
        .load_data  (load_data)
    );

    // no memory write may slip out while the core sits in reset
    always_comb begin
        dmem_req    = lsu_req;
        dmem_req.we = lsu_req.we & ~rst;
    end

    pc_unit #(.reset_pc(reset_pc)) u_pc (
        .clk    (clk),
        .rst    (rst),
        .branch (ctrl.branch),
        .cond   (alu_cond),
        .imm    (imm),
        .pc     (pc)
    );

    always_comb begin
        if (ctrl.mem_rd) begin
            wb_data = load_data;
        end else if (ctrl.wb_pc4) begin
            wb_data = pc + xlen_t'(4);   // jal link
        end else begin
            wb_data = alu_result;
        end
    end

endmodule

/* dv/tb_core.sv */
`timescale 1ns/1ps

module tb_core import rvseed_pkg::*; ();

    localparam int    last_idx = 250;          // slot of the final jal to itself
    localparam addr_t last_pc  = 64'd1000;

    logic      clk;
    logic      rst = 1'b1;
    logic      rst_q = 1'b0;                    // rst one edge later
    addr_t     pc;
    inst_t     instr;
    dmem_req_t dmem_req;
    xlen_t     dmem_rdata;
    inst_t     imem [256];
    xlen_t     dmem [32];
    logic [31:0] lcg_state = 32'd3;
    int        hits [6];
    int        errs [6];
    int        unreached = 0;

    // reference ISA model state and the effects of the instruction at m_pc
    addr_t      m_pc;
    xlen_t      m_regs [32];
    xlen_t      m_mem [32];
    int         m_src [32];                     // test that owns the value in each register
    addr_t      e_next = '0;
    reg_idx_t   e_rd = '0;
    logic       e_rd_we = 1'b0;
    xlen_t      e_val = '0;
    int         e_src = 1;
    logic       e_we = 1'b0;
    addr_t      e_addr = '0;
    logic [7:0] e_be = '0;
    xlen_t      e_wdata = '0;
    int         e_cls = 1;

    // {funct7[5], funct3, opcode} for add sub and or xor slt sltu sll srl sra addw sllw
    logic [10:0] r_ops [12] = '{
        {1'b0, 3'b000, opc_op}, {1'b1, 3'b000, opc_op}, {1'b0, 3'b111, opc_op},
        {1'b0, 3'b110, opc_op}, {1'b0, 3'b100, opc_op}, {1'b0, 3'b010, opc_op},
        {1'b0, 3'b011, opc_op}, {1'b0, 3'b001, opc_op}, {1'b0, 3'b101, opc_op},
        {1'b1, 3'b101, opc_op}, {1'b0, 3'b000, opc_op_32}, {1'b0, 3'b001, opc_op_32}
    };
    logic [2:0] ld_f3 [3] = '{3'b011, 3'b010, 3'b100};   // ld lw lbu
    logic [2:0] st_f3 [3] = '{3'b011, 3'b010, 3'b000};   // sd sw sb
    logic [2:0] br_f3 [4] = '{3'b000, 3'b001, 3'b100, 3'b110};

    rvseed_core #(.reset_pc(64'h0)) UUT (
        .clk        (clk),
        .rst        (rst),
        .pc         (pc),
        .instr      (instr),
        .dmem_req   (dmem_req),
        .dmem_rdata (dmem_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ********************************************************************
    // memory models
    // ********************************************************************
    assign instr      = $isunknown(pc) ? '0 : imem[pc[9:2]];
    assign dmem_rdata = $isunknown(dmem_req.addr) ? '0 : dmem[dmem_req.addr[7:3]];

    always @(posedge clk) begin
        if (dmem_req.we) begin
            for (int i = 0; i < 8; i++) begin
                if (dmem_req.be[i]) begin
                    dmem[dmem_req.addr[7:3]][8*i +: 8] <= dmem_req.wdata[8*i +: 8];
                end
            end
        end
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int rnd(int n);
        return int'((next_rand() >> 8) % n);
    endfunction

    function automatic xlen_t fill_word(int i);
        return {32'(i) * 32'h9e37_79b9, 32'(i + 1) * 32'h85eb_ca6b};
    endfunction

    function automatic xlen_t lane_mask(logic [7:0] be);
        xlen_t m;
        for (int i = 0; i < 8; i++) begin
            m[8*i +: 8] = {8{be[i]}};
        end
        return m;
    endfunction

    function automatic inst_t enc_i(logic [31:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                    logic [4:0] rd, logic [6:0] opc);
        return {imm[11:0], rs1, f3, rd, opc};
    endfunction

    function automatic inst_t enc_s(logic [31:0] imm, logic [4:0] rs2, logic [2:0] f3);
        return {imm[11:5], rs2, 5'd0, f3, imm[4:0], opc_store};   // base is x0
    endfunction

    function automatic inst_t enc_b(logic [31:0] off, logic [4:0] rs2, logic [4:0] rs1,
                                    logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], opc_branch};
    endfunction

    function automatic inst_t enc_j(logic [31:0] off, logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, opc_jal};
    endfunction

    // ********************************************************************
    // program generator
    // ********************************************************************
    task automatic build_program();
        int          k;
        int          n;
        int          s;
        logic [31:0] v;
        logic [31:0] off;
        logic [10:0] op;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        for (int i = 0; i < 256; i++) begin
            imem[i] = '0;
        end
        k = 0;
        for (int r = 1; r <= 8; r++) begin
            v = next_rand();
            imem[k]     = {v[31:12], 5'(r), opc_lui};
            imem[k + 1] = enc_i(v, 5'(r), 3'b000, 5'(r), opc_op_imm);
            k += 2;
        end
        imem[k]     = enc_i(32'd5, 5'd1, 3'b000, 5'd0, opc_op_imm);   // write to x0
        imem[k + 1] = enc_s(32'd0, 5'd0, 3'b011);
        imem[k + 2] = enc_i(32'd12, 5'd0, 3'b010, 5'd9, opc_load);   // word with top bit set
        imem[k + 3] = enc_s(32'd16, 5'd9, 3'b011);
        imem[k + 4] = enc_i(32'd12, 5'd0, 3'b100, 5'd10, opc_load);  // byte with top bit set
        imem[k + 5] = enc_s(32'd24, 5'd10, 3'b011);
        k += 6;
        while (k < last_idx) begin
            v   = next_rand();
            rd  = 5'(rnd(16));
            rs1 = 5'(rnd(16));
            rs2 = 5'(rnd(16));
            s   = rnd(3);
            off = 32'(rnd(256)) & ~((s == 0) ? 32'd7 : (s == 1) ? 32'd3 : 32'd0);
            n   = 1 + rnd(4);
            if (k + n > last_idx) begin
                n = last_idx - k;   // forward only, never past the final jal
            end
            case (rnd(8))
                0, 1: begin
                    op      = r_ops[rnd(12)];
                    imem[k] = {1'b0, op[10], 5'b0, rs2, rs1, op[9:7], rd, op[6:0]};
                end
                2:       imem[k] = enc_i(v, rs1, 3'b000, rd, opc_op_imm);
                3:       imem[k] = {v[31:12], rd, opc_lui};
                4:       imem[k] = enc_i(off, 5'd0, ld_f3[s], rd, opc_load);
                5:       imem[k] = enc_s(off, rs2, st_f3[s]);
                6:       imem[k] = enc_b(32'(n * 4), rs2, rs1, br_f3[rnd(4)]);
                default: imem[k] = enc_j(32'(n * 4), rd);
            endcase
            k++;
        end
        imem[last_idx] = enc_j(32'd0, 5'd0);
    endtask

    // ********************************************************************
    // reference model
    // ********************************************************************
    task automatic model_decode();
        inst_t       w;
        xlen_t       a;
        xlen_t       b;
        xlen_t       ea;
        xlen_t       dw;
        logic [31:0] t;
        logic [2:0]  f3;
        logic        taken;
        w  = imem[m_pc[9:2]];
        a  = m_regs[w[19:15]];
        b  = m_regs[w[24:20]];
        f3 = w[14:12];
        e_next  = m_pc + 64'd4;
        e_rd    = w[11:7];
        e_rd_we = 1'b0;
        e_val   = '0;
        e_src   = 1;
        e_we    = 1'b0;
        e_be    = '0;
        e_addr  = '0;
        e_wdata = '0;
        case (w[6:0])
            opc_op: begin
                e_rd_we = 1'b1;
                case ({w[30], f3})
                    4'b0000: e_val = a + b;
                    4'b1000: e_val = a - b;
                    4'b0001: e_val = a << b[5:0];
                    4'b0010: e_val = {63'b0, $signed(a) < $signed(b)};
                    4'b0011: e_val = {63'b0, a < b};
                    4'b0100: e_val = a ^ b;
                    4'b0101: e_val = a >> b[5:0];
                    4'b1101: e_val = $signed(a) >>> b[5:0];
                    4'b0110: e_val = a | b;
                    default: e_val = a & b;
                endcase
            end
            opc_op_32: begin
                e_rd_we = 1'b1;
                t       = (f3 == 3'b000) ? a[31:0] + b[31:0] : a[31:0] << b[4:0];
                e_val   = {{32{t[31]}}, t};
            end
            opc_op_imm: begin
                e_rd_we = 1'b1;
                e_val   = a + {{52{w[31]}}, w[31:20]};
            end
            opc_lui: begin
                e_rd_we = 1'b1;
                e_val   = {{32{w[31]}}, w[31:12], 12'b0};
            end
            opc_load: begin
                ea      = a + {{52{w[31]}}, w[31:20]};
                dw      = m_mem[ea[7:3]] >> {ea[2:0], 3'b000};
                e_rd_we = 1'b1;
                e_src   = 3;
                case (f3)
                    3'b011:  e_val = dw;
                    3'b010:  e_val = {{32{dw[31]}}, dw[31:0]};
                    default: e_val = {56'b0, dw[7:0]};
                endcase
            end
            opc_store: begin
                ea      = a + {{52{w[31]}}, w[31:25], w[11:7]};
                e_we    = 1'b1;
                e_addr  = {ea[63:3], 3'b000};
                e_wdata = b << {ea[2:0], 3'b000};
                e_cls   = (w[24:20] == 5'd0) ? 5 : m_src[w[24:20]];
                case (f3)
                    3'b011:  e_be = 8'hff;
                    3'b010:  e_be = 8'h0f << ea[2:0];
                    default: e_be = 8'h01 << ea[2:0];
                endcase
            end
            opc_branch: begin
                case (f3)
                    3'b000:  taken = (a == b);
                    3'b001:  taken = (a != b);
                    3'b100:  taken = $signed(a) < $signed(b);
                    default: taken = a < b;
                endcase
                if (taken) begin
                    e_next = m_pc + {{51{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
                end
            end
            opc_jal: begin
                e_rd_we = 1'b1;
                e_val   = m_pc + 64'd4;
                e_src   = 2;
                e_next  = m_pc + {{43{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            end
            default: ;
        endcase
    endtask

    always @(negedge clk) begin
        model_decode();
    end

    always @(posedge clk) begin
        rst_q <= rst;
        if (rst_q) begin
            hits[0]++;
        end
        if (rst) begin
            m_pc <= '0;
            for (int i = 1; i < 32; i++) begin
                m_regs[i] <= '0;
            end
        end else begin
            m_pc <= e_next;
            hits[2]++;
            if (e_rd_we && e_rd != '0) begin
                m_regs[e_rd] <= e_val;
                m_src[e_rd]  <= e_src;
            end
            if (e_we) begin
                for (int i = 0; i < 8; i++) begin
                    if (e_be[i]) begin
                        m_mem[e_addr[7:3]][8*i +: 8] <= e_wdata[8*i +: 8];
                    end
                end
                hits[4]++;
                hits[e_cls]++;
            end
        end
    end

    // ********************************************************************
    // checks
    // ********************************************************************
    reset_chk: assert property (@(posedge clk) rst_q |-> (pc == '0 && !dmem_req.we))
        else begin
            errs[0]++;
            $display("[FAIL] reset pc %h dmem_req.we %h expected 0 and 0",
                     $sampled(pc), $sampled(dmem_req.we));
        end

    pc_chk: assert property (@(posedge clk) disable iff (rst) pc == m_pc)
        else begin
            errs[2]++;
            $display("[FAIL] pc %h expected %h", $sampled(pc), $sampled(m_pc));
        end

    lane_chk: assert property (@(posedge clk) disable iff (rst)
            dmem_req.we == e_we && (!e_we || (dmem_req.addr == e_addr && dmem_req.be == e_be)))
        else begin
            errs[4]++;
            $display("[FAIL] dmem_req we/addr/be %h/%h/%h expected %h/%h/%h",
                     $sampled(dmem_req.we), $sampled(dmem_req.addr), $sampled(dmem_req.be),
                     $sampled(e_we), $sampled(e_addr), $sampled(e_be));
        end

    data_chk: assert property (@(posedge clk) disable iff (rst)
            e_we |-> ((dmem_req.wdata & lane_mask(e_be)) == (e_wdata & lane_mask(e_be))))
        else begin
            errs[e_cls]++;
            $display("[FAIL] dmem_req.wdata %h expected %h under be %h",
                     $sampled(dmem_req.wdata), $sampled(e_wdata), $sampled(e_be));
        end

    task automatic report_test(int k, string name);
        $display("%-8s %0d checks, %0d errors", name, hits[k], errs[k]);
        if (hits[k] == 0) begin
            $display("%s: the program never reached this check", name);
            unreached++;
        end
    endtask

    initial begin
        int n;
        int total;
        bit ok;
        build_program();
        for (int i = 0; i < 32; i++) begin
            dmem[i]   = fill_word(i);
            m_mem[i]  = fill_word(i);
            m_regs[i] = '0;
            m_src[i]  = 1;
        end
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        n = 0;
        while ((rst || rst_q) && n < 20) begin
            @(negedge clk);
            n++;
        end
        ok = !(rst || rst_q);
        if (!ok) begin
            $display("timeout: reset release was never seen");
        end
        report_test(0, "reset");
        n = 0;
        while (ok && pc !== last_pc && n < 1000) begin
            @(negedge clk);
            n++;
        end
        if (ok && pc !== last_pc) begin
            ok = 1'b0;
            $display("timeout: the core never reached the final jal");
        end
        repeat (3) @(negedge clk);   // parked jal retires a few times
        report_test(1, "alu");
        report_test(2, "control");
        report_test(3, "loads");
        report_test(4, "lanes");
        report_test(5, "x0");
        total = 0;
        for (int k = 0; k < 6; k++) begin
            total += errs[k];
        end
        $display("summary: 6 tests, %0d errors, %0d unreached", total, unreached);
        if (ok && total == 0 && unreached == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* src.f */
verilog/rvseed_pkg.sv
verilog/rvseed_ctrl.sv
verilog/alu.sv
verilog/reg_file.sv
verilog/imm_gen.sv
verilog/lsu.sv
verilog/pc_unit.sv
verilog/rvseed_core.sv
dv/tb_core.sv
